//--- all.f
logic/mem_bridge_pkg.sv
logic/lane_merge.sv
logic/dcache_ctrl.sv
logic/dcache_datapath.sv
logic/data_mem_bridge.sv
verif/data_mem_bridge_sva.sv
verif/bus_mem_model.sv
verif/tb_data_mem_bridge.sv

//--- logic/data_mem_bridge.sv
`timescale 1ns/100ps

module data_mem_bridge #(
    parameter int NUM_LANES = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n_i,

    // Memory-stage lanes
    input  logic [NUM_LANES-1:0]                                   lane_ce_i,
    input  logic [NUM_LANES-1:0]                                   lane_we_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::WORD_STRB_W-1:0]  lane_sel_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::ADDR_W-1:0]       lane_addr_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::WORD_W-1:0]       lane_wdata_i,
    output logic [NUM_LANES-1:0]                                   lane_addr_ok_o,
    output logic [NUM_LANES-1:0]                                   lane_data_ok_o,
    output logic [mem_bridge_pkg::WORD_W-1:0]                      lane_rdata_o,

    // Bus read side
    output logic                                                   rd_req_o,
    output logic [mem_bridge_pkg::ADDR_W-1:0]                      rd_addr_o,
    input  logic                                                   rd_rdy_i,
    input  logic                                                   ret_valid_i,
    input  mem_bridge_pkg::line_t                                  ret_data_i,

    // Bus write side
    output logic                                                   wr_req_o,
    output logic [mem_bridge_pkg::ADDR_W-1:0]                      wr_addr_o,
    output logic [mem_bridge_pkg::LINE_STRB_W-1:0]                 wr_strb_o,
    output mem_bridge_pkg::line_t                                  wr_data_o,
    input  logic                                                   wr_rdy_i
);

    import mem_bridge_pkg::*;

    logic                    req;
    logic                    req_we;
    logic [WORD_STRB_W-1:0]  req_sel;
    logic [ADDR_W-1:0]       req_addr;
    logic [WORD_W-1:0]       req_wdata;
    logic                    idle;
    logic                    accept;
    logic                    done;

    lane_merge #(
        .NUM_LANES (NUM_LANES)
    ) u_lane_merge (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .lane_ce_i      (lane_ce_i),
        .lane_we_i      (lane_we_i),
        .lane_sel_i     (lane_sel_i),
        .lane_addr_i    (lane_addr_i),
        .lane_wdata_i   (lane_wdata_i),
        .idle_i         (idle),
        .done_i         (done),
        .lane_addr_ok_o (lane_addr_ok_o),
        .lane_data_ok_o (lane_data_ok_o),
        .req_o          (req),
        .req_we_o       (req_we),
        .req_sel_o      (req_sel),
        .req_addr_o     (req_addr),
        .req_wdata_o    (req_wdata)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req),
        .req_we_i    (req_we),
        .rd_rdy_i    (rd_rdy_i),
        .ret_valid_i (ret_valid_i),
        .wr_rdy_i    (wr_rdy_i),
        .idle_o      (idle),
        .accept_o    (accept),
        .rd_req_o    (rd_req_o),
        .wr_req_o    (wr_req_o),
        .done_o      (done)
    );

    dcache_datapath u_dcache_datapath (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .accept_i    (accept),
        .ret_valid_i (ret_valid_i),
        .req_we_i    (req_we),
        .req_sel_i   (req_sel),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .ret_data_i  (ret_data_i),
        .rd_addr_o   (rd_addr_o),
        .wr_addr_o   (wr_addr_o),
        .wr_strb_o   (wr_strb_o),
        .wr_data_o   (wr_data_o),
        .rdata_o     (lane_rdata_o)
    );

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic clk,
    input  logic rst_n_i,

    input  logic req_i,
    input  logic req_we_i,
    input  logic rd_rdy_i,
    input  logic ret_valid_i,
    input  logic wr_rdy_i,

    output logic idle_o,
    output logic accept_o,
    output logic rd_req_o,
    output logic wr_req_o,
    output logic done_o
);

    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] RD_REQ  = 3'd1;
    localparam logic [2:0] RD_WAIT = 3'd2;
    localparam logic [2:0] WR_REQ  = 3'd3;
    localparam logic [2:0] DONE    = 3'd4;

    logic [2:0] state_q;
    logic [2:0] state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = req_we_i ? WR_REQ : RD_REQ;
                end
            end
            // Request level held until the bus takes it
            RD_REQ: begin
                if (rd_rdy_i) begin
                    state_d = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (ret_valid_i) begin
                    state_d = DONE;
                end
            end
            WR_REQ: begin
                if (wr_rdy_i) begin
                    state_d = DONE;
                end
            end
            // Single cycle completion, then free again
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign idle_o   = (state_q == IDLE);
    assign accept_o = req_i & idle_o;
    assign rd_req_o = (state_q == RD_REQ);
    assign wr_req_o = (state_q == WR_REQ);
    assign done_o   = (state_q == DONE);

endmodule

//--- logic/dcache_datapath.sv
`timescale 1ns/100ps

module dcache_datapath (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  logic                                    accept_i,
    input  logic                                    ret_valid_i,

    input  logic                                    req_we_i,
    input  logic [mem_bridge_pkg::WORD_STRB_W-1:0]  req_sel_i,
    input  logic [mem_bridge_pkg::ADDR_W-1:0]       req_addr_i,
    input  logic [mem_bridge_pkg::WORD_W-1:0]       req_wdata_i,

    input  mem_bridge_pkg::line_t                   ret_data_i,

    output logic [mem_bridge_pkg::ADDR_W-1:0]       rd_addr_o,
    output logic [mem_bridge_pkg::ADDR_W-1:0]       wr_addr_o,
    output logic [mem_bridge_pkg::LINE_STRB_W-1:0]  wr_strb_o,
    output mem_bridge_pkg::line_t                   wr_data_o,
    output logic [mem_bridge_pkg::WORD_W-1:0]       rdata_o
);

    import mem_bridge_pkg::*;

    // Byte bits of the offset, the rest picks the word
    localparam int BYTE_OFS_W = $clog2(WORD_STRB_W);
    localparam int WORD_IDX_W = OFFSET_W - BYTE_OFS_W;

    mem_addr_u               addr_q;
    mem_addr_u               line_addr;
    logic [WORD_STRB_W-1:0]  sel_q;
    logic [WORD_W-1:0]       wdata_q;
    logic [WORD_W-1:0]       rdata_q;
    logic [WORD_IDX_W-1:0]   word_idx;
    line_t                   wr_line;

    // Request capture at accept
    always_ff @(posedge clk) begin
        if (accept_i) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
    end

    // Reads carry no strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sel_q <= '0;
        end else if (accept_i) begin
            sel_q <= req_we_i ? req_sel_i : '0;
        end
    end

    assign word_idx = addr_q.fields.offset[OFFSET_W-1:BYTE_OFS_W];

    // Line aligned bus address
    always_comb begin
        line_addr = addr_q;
        line_addr.fields.offset = '0;
    end

    assign rd_addr_o = line_addr.raw;
    assign wr_addr_o = line_addr.raw;

    // Write word lands in its own slot, other slots stay zero
    always_comb begin
        wr_line = '0;
        wr_line[word_idx] = wdata_q;
    end

    assign wr_data_o = wr_line;
    assign wr_strb_o = LINE_STRB_W'(sel_q) << (WORD_STRB_W * word_idx);

    // Returned line narrowed to the requested word
    always_ff @(posedge clk) begin
        if (ret_valid_i) begin
            rdata_q <= ret_data_i[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- logic/lane_merge.sv
`timescale 1ns/100ps

module lane_merge #(
    parameter int NUM_LANES = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n_i,

    input  logic [NUM_LANES-1:0]                                   lane_ce_i,
    input  logic [NUM_LANES-1:0]                                   lane_we_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::WORD_STRB_W-1:0]  lane_sel_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::ADDR_W-1:0]       lane_addr_i,
    input  logic [NUM_LANES-1:0][mem_bridge_pkg::WORD_W-1:0]       lane_wdata_i,

    input  logic                                                   idle_i,
    input  logic                                                   done_i,

    output logic [NUM_LANES-1:0]                                   lane_addr_ok_o,
    output logic [NUM_LANES-1:0]                                   lane_data_ok_o,

    output logic                                                   req_o,
    output logic                                                   req_we_o,
    output logic [mem_bridge_pkg::WORD_STRB_W-1:0]                 req_sel_o,
    output logic [mem_bridge_pkg::ADDR_W-1:0]                      req_addr_o,
    output logic [mem_bridge_pkg::WORD_W-1:0]                      req_wdata_o
);

    logic [NUM_LANES-1:0] grant;
    logic [NUM_LANES-1:0] owner_q;
    logic                 accept;

    // Lowest set bit of ce wins
    assign grant  = lane_ce_i & (~lane_ce_i + NUM_LANES'(1));
    assign req_o  = |lane_ce_i;
    assign accept = req_o & idle_i;

    // One-hot grant so an AND-OR mux is enough
    always_comb begin
        req_we_o    = 1'b0;
        req_sel_o   = '0;
        req_addr_o  = '0;
        req_wdata_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (grant[i]) begin
                req_we_o    = req_we_o | lane_we_i[i];
                req_sel_o   = req_sel_o | lane_sel_i[i];
                req_addr_o  = req_addr_o | lane_addr_i[i];
                req_wdata_o = req_wdata_o | lane_wdata_i[i];
            end
        end
    end

    assign lane_addr_ok_o = grant & {NUM_LANES{idle_i}};

    // Remember who asked so the completion goes back to it
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            owner_q <= '0;
        end else if (accept) begin
            owner_q <= grant;
        end
    end

    assign lane_data_ok_o = owner_q & {NUM_LANES{done_i}};

endmodule

//--- logic/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // Bus and word geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int LINE_STRB_W    = LINE_W / 8;
    localparam int WORD_STRB_W    = WORD_W / 8;

    // Physical address split
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } mem_addr_fields_t;

    // Same 32 bits seen as a plain address or as cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        mem_addr_fields_t  fields;
    } mem_addr_u;

    // Word 0 sits in the low 32 bits of the line
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

endpackage

//--- verif/bus_mem_model.sv
`timescale 1ns/100ps

module bus_mem_model (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  logic                                    rd_req_i,
    input  logic [mem_bridge_pkg::ADDR_W-1:0]       rd_addr_i,
    output logic                                    rd_rdy_o,
    output logic                                    ret_valid_o,
    output mem_bridge_pkg::line_t                   ret_data_o,

    input  logic                                    wr_req_i,
    input  logic [mem_bridge_pkg::ADDR_W-1:0]       wr_addr_i,
    input  logic [mem_bridge_pkg::LINE_STRB_W-1:0]  wr_strb_i,
    input  mem_bridge_pkg::line_t                   wr_data_i,
    output logic                                    wr_rdy_o
);

    import mem_bridge_pkg::*;

    localparam int MAX_DELAY = 3;

    line_t              mem [2**INDEX_W];
    logic [LINE_W-1:0]  wr_flat;
    logic [LINE_W-1:0]  line_tmp;
    logic [INDEX_W-1:0] ret_idx;
    logic               rd_busy;
    int unsigned        rd_delay;
    int unsigned        ret_delay;
    int unsigned        wr_delay;

    // Same fill rule the testbench uses for its reference copy
    function automatic logic [WORD_W-1:0] fill_word(input logic [11:0] a);
        return {a, 4'h5, ~a, 4'hA};
    endfunction

    assign wr_flat = wr_data_i;

    initial begin
        rd_rdy_o    = 1'b0;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_rdy_o    = 1'b0;
        rd_busy     = 1'b0;
        for (int i = 0; i < 2**INDEX_W; i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem[i][w] = fill_word(12'(i * 16 + w * 4));
            end
        end
    end

    // Outputs change on the falling edge, away from DUT sampling
    always @(negedge clk) begin
        rd_rdy_o    <= 1'b0;
        wr_rdy_o    <= 1'b0;
        ret_valid_o <= 1'b0;
        if (!rst_n_i) begin
            rd_busy  = 1'b0;
            rd_delay = $urandom_range(MAX_DELAY);
            wr_delay = $urandom_range(MAX_DELAY);
        end else begin
            if (rd_busy) begin
                if (ret_delay == 0) begin
                    ret_valid_o <= 1'b1;
                    ret_data_o  <= mem[ret_idx];
                    rd_busy = 1'b0;
                end else begin
                    ret_delay--;
                end
            end else if (rd_req_i) begin
                if (rd_delay == 0) begin
                    rd_rdy_o <= 1'b1;
                    rd_busy   = 1'b1;
                    ret_idx   = rd_addr_i[OFFSET_W +: INDEX_W];
                    ret_delay = $urandom_range(MAX_DELAY);
                    rd_delay  = $urandom_range(MAX_DELAY);
                end else begin
                    rd_delay--;
                end
            end
            if (wr_req_i) begin
                if (wr_delay == 0) begin
                    wr_rdy_o <= 1'b1;
                    line_tmp = mem[wr_addr_i[OFFSET_W +: INDEX_W]];
                    for (int b = 0; b < LINE_STRB_W; b++) begin
                        if (wr_strb_i[b]) begin
                            line_tmp[b*8 +: 8] = wr_flat[b*8 +: 8];
                        end
                    end
                    mem[wr_addr_i[OFFSET_W +: INDEX_W]] = line_tmp;
                    wr_delay = $urandom_range(MAX_DELAY);
                end else begin
                    wr_delay--;
                end
            end
        end
    end

endmodule

//--- verif/data_mem_bridge_sva.sv
`timescale 1ns/100ps

module data_mem_bridge_sva #(
    parameter int NUM_LANES = 2
) (
    input logic                                    clk,
    input logic                                    rst_n_i,
    input logic [NUM_LANES-1:0]                    lane_ce_i,
    input logic [NUM_LANES-1:0]                    lane_addr_ok_o,
    input logic [NUM_LANES-1:0]                    lane_data_ok_o,
    input logic                                    rd_req_o,
    input logic [mem_bridge_pkg::ADDR_W-1:0]       rd_addr_o,
    input logic                                    rd_rdy_i,
    input logic                                    wr_req_o,
    input logic [mem_bridge_pkg::ADDR_W-1:0]       wr_addr_o,
    input logic [mem_bridge_pkg::LINE_STRB_W-1:0]  wr_strb_o,
    input mem_bridge_pkg::line_t                   wr_data_o,
    input logic                                    wr_rdy_i
);

    import mem_bridge_pkg::*;

    logic                 seen_ce;
    logic                 outstanding;
    logic [NUM_LANES-1:0] owner;
    int                   fail_count;

    // Tracks the lane that holds the single open access
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            seen_ce     <= 1'b0;
            outstanding <= 1'b0;
            owner       <= '0;
        end else begin
            if (|lane_ce_i) begin
                seen_ce <= 1'b1;
            end
            if (|lane_addr_ok_o) begin
                outstanding <= 1'b1;
                owner       <= lane_addr_ok_o;
            end else if (|lane_data_ok_o) begin
                outstanding <= 1'b0;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!seen_ce && !(|lane_ce_i)) |->
        (!rd_req_o && !wr_req_o && lane_addr_ok_o == '0 && lane_data_ok_o == '0))
        else begin
            fail_count++;
            $error("Bus or lane strobe active before any lane request");
        end

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rd_req_o && !rd_rdy_i) |=> (rd_req_o && $stable(rd_addr_o)))
        else begin
            fail_count++;
            $error("Read request dropped or changed under back-pressure");
        end

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_req_o && !wr_rdy_i) |=>
        (wr_req_o && $stable(wr_addr_o) && $stable(wr_strb_o) && $stable(wr_data_o)))
        else begin
            fail_count++;
            $error("Write request dropped or changed under back-pressure");
        end

    rd_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_req_o |-> rd_addr_o[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("Read bus address is not line aligned");
        end

    wr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_req_o |-> wr_addr_o[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("Write bus address is not line aligned");
        end

    single_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding |-> lane_addr_ok_o == '0)
        else begin
            fail_count++;
            $error("Second addr_ok while an access is still open");
        end

    owner_only: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|lane_data_ok_o) |-> (lane_data_ok_o == owner))
        else begin
            fail_count++;
            $error("data_ok went to a lane that does not own the access");
        end

endmodule

bind data_mem_bridge data_mem_bridge_sva #(
    .NUM_LANES (NUM_LANES)
) sva0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .lane_ce_i      (lane_ce_i),
    .lane_addr_ok_o (lane_addr_ok_o),
    .lane_data_ok_o (lane_data_ok_o),
    .rd_req_o       (rd_req_o),
    .rd_addr_o      (rd_addr_o),
    .rd_rdy_i       (rd_rdy_i),
    .wr_req_o       (wr_req_o),
    .wr_addr_o      (wr_addr_o),
    .wr_strb_o      (wr_strb_o),
    .wr_data_o      (wr_data_o),
    .wr_rdy_i       (wr_rdy_i)
);

//--- verif/tb_data_mem_bridge.sv
`timescale 1ns/100ps

module tb_data_mem_bridge;

    import mem_bridge_pkg::*;

    localparam int NUM_LANES = 2;
    localparam int TIMEOUT   = 200;

    logic                                   clk;
    logic                                   rst_n;
    logic [NUM_LANES-1:0]                   lane_ce;
    logic [NUM_LANES-1:0]                   lane_we;
    logic [NUM_LANES-1:0][WORD_STRB_W-1:0]  lane_sel;
    logic [NUM_LANES-1:0][ADDR_W-1:0]       lane_addr;
    logic [NUM_LANES-1:0][WORD_W-1:0]       lane_wdata;
    logic [NUM_LANES-1:0]                   lane_addr_ok;
    logic [NUM_LANES-1:0]                   lane_data_ok;
    logic [WORD_W-1:0]                      lane_rdata;
    logic                                   rd_req;
    logic [ADDR_W-1:0]                      rd_addr;
    logic                                   rd_rdy;
    logic                                   ret_valid;
    line_t                                  ret_data;
    logic                                   wr_req;
    logic [ADDR_W-1:0]                      wr_addr;
    logic [LINE_STRB_W-1:0]                 wr_strb;
    line_t                                  wr_data;
    logic                                   wr_rdy;

    logic [LINE_W-1:0]      exp_mem [2**INDEX_W];
    logic [ADDR_W-1:0]      seen_rd_addr;
    logic [ADDR_W-1:0]      seen_wr_addr;
    logic [LINE_STRB_W-1:0] seen_strb;
    logic [LINE_W-1:0]      seen_wdata;
    int                     checks;
    int                     errors;
    int                     checks_mark;
    int                     errors_mark;

    data_mem_bridge #(.NUM_LANES(NUM_LANES)) dut0 (
        .clk(clk), .rst_n_i(rst_n),
        .lane_ce_i(lane_ce), .lane_we_i(lane_we), .lane_sel_i(lane_sel),
        .lane_addr_i(lane_addr), .lane_wdata_i(lane_wdata),
        .lane_addr_ok_o(lane_addr_ok), .lane_data_ok_o(lane_data_ok), .lane_rdata_o(lane_rdata),
        .rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_rdy_i(rd_rdy),
        .ret_valid_i(ret_valid), .ret_data_i(ret_data),
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_strb_o(wr_strb),
        .wr_data_o(wr_data), .wr_rdy_i(wr_rdy)
    );

    bus_mem_model mem0 (
        .clk(clk), .rst_n_i(rst_n),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_rdy_o(rd_rdy),
        .ret_valid_o(ret_valid), .ret_data_o(ret_data),
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_strb_i(wr_strb),
        .wr_data_i(wr_data), .wr_rdy_o(wr_rdy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Last read and write requests seen on the bus
    always @(negedge clk) begin
        if (rd_req) begin
            seen_rd_addr = rd_addr;
        end
        if (wr_req) begin
            seen_wr_addr = wr_addr;
            seen_strb    = wr_strb;
            seen_wdata   = wr_data;
        end
    end

    function automatic logic [WORD_W-1:0] fill_word(input logic [11:0] a);
        return {a, 4'h5, ~a, 4'hA};
    endfunction

    task automatic compare(input string name, input logic [LINE_W-1:0] exp,
                           input logic [LINE_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // One lane access from ce up to data_ok
    task automatic access(input int lane, input logic we, input logic [3:0] sel,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output time t_ok, output time t_done);
        int n;
        @(negedge clk);
        lane_ce[lane]    = 1'b1;
        lane_we[lane]    = we;
        lane_sel[lane]   = sel;
        lane_addr[lane]  = addr;
        lane_wdata[lane] = wdata;
        n = 0;
        #1;
        while (!lane_addr_ok[lane] && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!lane_addr_ok[lane]) begin
            $display("Timeout: lane %0d never received addr_ok", lane);
            $display("tests failed");
            $finish;
        end else begin
            t_ok = $time;
            @(negedge clk);
            lane_ce[lane] = 1'b0;
            n = 0;
            while (!lane_data_ok[lane] && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!lane_data_ok[lane]) begin
                $display("Timeout: lane %0d never received data_ok", lane);
                $display("tests failed");
                $finish;
            end else begin
                rdata  = lane_rdata;
                t_done = $time;
            end
        end
    endtask

    task automatic read_check(input int lane, input logic [31:0] addr, input string name);
        logic [31:0] rdata;
        time         t_ok;
        time         t_done;
        access(lane, 1'b0, 4'h0, addr, 32'h0, rdata, t_ok, t_done);
        compare({name, " address"}, {addr[31:4], 4'h0}, seen_rd_addr);
        compare(name, exp_mem[addr[11:4]][addr[3:2]*32 +: 32], rdata);
    endtask

    task automatic write_word(input int lane, input logic [31:0] addr, input logic [3:0] sel,
                              input logic [31:0] data, input string name);
        logic [31:0]       rdata;
        logic [LINE_W-1:0] exp_line;
        time               t_ok;
        time               t_done;
        access(lane, 1'b1, sel, addr, data, rdata, t_ok, t_done);
        exp_line = '0;
        exp_line[addr[3:2]*32 +: 32] = data;
        compare({name, " address"}, {addr[31:4], 4'h0}, seen_wr_addr);
        compare({name, " strobe"}, LINE_W'(LINE_STRB_W'(sel) << (4 * addr[3:2])), seen_strb);
        compare({name, " line"}, exp_line, seen_wdata);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                exp_mem[addr[11:4]][addr[3:2]*32 + b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    logic [31:0] addr;
    logic [31:0] rdata0;
    logic [31:0] rdata1;
    time         t_ok0;
    time         t_ok1;
    time         t_done0;
    time         t_done1;

    initial begin
        void'($urandom(38));
        rst_n      = 1'b0;
        lane_ce    = '0;
        lane_we    = '0;
        lane_sel   = '0;
        lane_addr  = '0;
        lane_wdata = '0;
        for (int i = 0; i < 2**INDEX_W; i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                exp_mem[i][w*32 +: 32] = fill_word(12'(i * 16 + w * 4));
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (8) begin
            @(negedge clk);
            checks++;
            assert (!rd_req && !wr_req && lane_addr_ok == '0 && lane_data_ok == '0) else begin
                errors++;
                $display("Bus or lane strobe active while every lane is idle after reset");
            end
        end
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            read_check(i % 2, $urandom() & ~32'h3, "read");
        end
        end_test("read");

        for (int i = 0; i < 6; i++) begin
            addr = $urandom() & ~32'h3;
            write_word(i % 2, addr, 4'($urandom_range(1, 15)), $urandom(), "write");
            read_check((i + 1) % 2, addr, "read back");
        end
        end_test("write_read");

        // Both lanes ask in the same cycle
        addr = $urandom() & ~32'h3;
        fork
            access(0, 1'b0, 4'h0, addr, 32'h0, rdata0, t_ok0, t_done0);
            access(1, 1'b0, 4'h0, addr ^ 32'h0000_0ff4, 32'h0, rdata1, t_ok1, t_done1);
        join
        checks++;
        assert (t_ok0 < t_ok1 && t_done0 < t_ok1) else begin
            errors++;
            $display("Lane 1 was granted before lane 0 finished its access");
        end
        compare("priority lane 0", exp_mem[addr[11:4]][addr[3:2]*32 +: 32], rdata0);
        addr = addr ^ 32'h0000_0ff4;
        compare("priority lane 1", exp_mem[addr[11:4]][addr[3:2]*32 +: 32], rdata1);
        end_test("priority");

        // Random mix, the memory model varies its ready delays
        for (int i = 0; i < 20; i++) begin
            addr = $urandom() & ~32'h3;
            if ($urandom_range(0, 1) == 1) begin
                write_word($urandom_range(0, 1), addr, 4'($urandom_range(1, 15)), $urandom(),
                           "mixed write");
            end else begin
                read_check($urandom_range(0, 1), addr, "mixed read");
            end
        end
        end_test("backpressure");

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.sva0.fail_count);
        if (errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
